//--- verilog.f
logic/ec_field_pkg.sv
logic/ec_point_pkg.sv
logic/mult_if.sv
logic/mod_mult.sv
logic/mult_arbiter.sv
logic/point_dbl.sv
logic/point_add.sv
logic/point_mult.sv
logic/ec_scalar_top.sv
test/ec_scalar_checker.sv
test/tb_ec_scalar.sv

//--- Makefile
TOP       ?= tb_ec_scalar
FILELIST  ?= verilog.f
SRCS      ?= $(shell grep -v '^+' $(FILELIST))
BUILD     ?= build
LOG       ?= $(BUILD)/sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
BIN       := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILD)

//--- test/tb_ec_scalar.sv
// Testbench top with clock, reset, affine reference model, test table, stimulus loop and timeout
module tb_ec_scalar;
  import ec_point_pkg::*;

  localparam int P_MOD   = 251;
  localparam int B_COEF  = 7;
  localparam int MAX_ENT = 32;

  // Affine point of the model, inf marks the point at infinity
  typedef struct packed {
    logic inf;
    int   x;
    int   y;
  } apt_t;

  logic       i_clk;
  logic       i_rst;
  req_kind_e  i_kind;
  logic [7:0] i_px, i_py, i_qx, i_qy, i_k;
  logic       i_val, i_rdy;
  logic       o_rdy, o_err, o_val;
  logic [7:0] o_x, o_y, o_z;
  logic       exp_inf;
  int         exp_x, exp_y;
  int         errors, checks;

  logic [31:0] rng = 32'hd917_aea3;
  apt_t        pts [256];
  int          n_pts;
  req_kind_e   e_kind [MAX_ENT];
  apt_t        e_p [MAX_ENT];
  apt_t        e_q [MAX_ENT];
  int          e_k [MAX_ENT];
  apt_t        e_res [MAX_ENT];
  int          n_ent = 0;
  int          cycles = 0;
  int          limit;

  ec_scalar_top i_ec_scalar_top (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_kind (i_kind),
    .i_px   (i_px),
    .i_py   (i_py),
    .i_qx   (i_qx),
    .i_qy   (i_qy),
    .i_k    (i_k),
    .i_val  (i_val),
    .o_rdy  (o_rdy),
    .o_x    (o_x),
    .o_y    (o_y),
    .o_z    (o_z),
    .o_err  (o_err),
    .o_val  (o_val),
    .i_rdy  (i_rdy)
  );

  ec_scalar_checker u_checker (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req_val (i_val),
    .i_req_rdy (o_rdy),
    .i_res_val (o_val),
    .i_res_rdy (i_rdy),
    .i_res_x   (o_x),
    .i_res_y   (o_y),
    .i_res_z   (o_z),
    .i_res_err (o_err),
    .i_exp_inf (exp_inf),
    .i_exp_x   (exp_x),
    .i_exp_y   (exp_y),
    .o_errors  (errors),
    .o_checks  (checks)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  function automatic int fadd(int a, int b);
    return (a + b) % P_MOD;
  endfunction

  function automatic int fsub(int a, int b);
    return (a - b + P_MOD) % P_MOD;
  endfunction

  function automatic int fmul(int a, int b);
    return (a * b) % P_MOD;
  endfunction

  // Inverse as a^(p-2)
  function automatic int finv(int a);
    int r;
    int b;
    int e;
    r = 1;
    b = a;
    e = P_MOD - 2;
    while (e > 0) begin
      if (e % 2 == 1) r = fmul(r, b);
      b = fmul(b, b);
      e = e / 2;
    end
    return r;
  endfunction

  function automatic apt_t pt_dbl(apt_t a);
    apt_t r;
    int   lam;
    r = '{inf: 1'b1, x: 0, y: 0};
    if (a.inf || a.y == 0) return r;
    lam = fmul(fmul(3, fmul(a.x, a.x)), finv(fadd(a.y, a.y)));
    r.inf = 1'b0;
    r.x = fsub(fmul(lam, lam), fadd(a.x, a.x));
    r.y = fsub(fmul(lam, fsub(a.x, r.x)), a.y);
    return r;
  endfunction

  function automatic apt_t pt_add(apt_t a, apt_t b);
    apt_t r;
    int   lam;
    r = '{inf: 1'b1, x: 0, y: 0};
    if (a.inf) return b;
    if (b.inf) return a;
    if (a.x == b.x) begin
      if (a.y == b.y) return pt_dbl(a);
      return r;
    end
    lam = fmul(fsub(b.y, a.y), finv(fsub(b.x, a.x)));
    r.inf = 1'b0;
    r.x = fsub(fsub(fmul(lam, lam), a.x), b.x);
    r.y = fsub(fmul(lam, fsub(a.x, r.x)), a.y);
    return r;
  endfunction

  // Plain repeated addition, independent of any bit ordering
  function automatic apt_t scalar_mult(apt_t p, int k);
    apt_t r;
    r = '{inf: 1'b1, x: 0, y: 0};
    for (int i = 0; i < k; i++) r = pt_add(r, p);
    return r;
  endfunction

  function automatic int point_order(apt_t p);
    apt_t r;
    int   n;
    r = p;
    n = 1;
    while (!r.inf) begin
      r = pt_add(r, p);
      n++;
    end
    return n;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int pick_point();
    return int'(next_rand() % 32'(n_pts));
  endfunction

  task automatic add_entry(input req_kind_e kind, input apt_t p, input apt_t q, input int k);
    e_kind[n_ent] = kind;
    e_p[n_ent]    = p;
    e_q[n_ent]    = q;
    e_k[n_ent]    = k;
    if (kind == REQ_ADD) e_res[n_ent] = pt_add(p, q);
    else e_res[n_ent] = scalar_mult(p, k);
    n_ent++;
  endtask

  // Request inputs of one entry, with its expected result for the checker
  task automatic present_entry(input int n);
    i_kind  <= e_kind[n];
    i_px    <= 8'(e_p[n].x);
    i_py    <= 8'(e_p[n].y);
    i_qx    <= 8'(e_q[n].x);
    i_qy    <= 8'(e_q[n].y);
    i_k     <= 8'(e_k[n]);
    i_val   <= 1'b1;
    exp_inf <= e_res[n].inf;
    exp_x   <= e_res[n].x;
    exp_y   <= e_res[n].y;
  endtask

  task automatic run_entry(input int n);
    int hold;
    hold = int'(next_rand() % 32'd5);
    @(posedge i_clk);
    present_entry(n);
    i_rdy <= (hold == 0);
    // Accepted on the rising edge after o_rdy is seen high
    @(negedge i_clk);
    while (!o_rdy) @(negedge i_clk);
    @(posedge i_clk);
    i_val <= 1'b0;
    @(negedge i_clk);
    while (!o_val) @(negedge i_clk);
    if (hold != 0) begin
      // Next request already waits at the inputs while the result is held
      @(posedge i_clk);
      if (n + 1 < n_ent) present_entry(n + 1);
      repeat (hold - 1) @(posedge i_clk);
      i_rdy <= 1'b1;
    end
  endtask

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: no progress after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    apt_t g;
    apt_t t2;
    apt_t none;
    apt_t neg;
    int   best;
    int   ord;
    int   a;
    int   b;
    i_rst   <= 1'b1;
    i_kind  <= REQ_MULT;
    i_px    <= '0;
    i_py    <= '0;
    i_qx    <= '0;
    i_qy    <= '0;
    i_k     <= '0;
    i_val   <= 1'b0;
    i_rdy   <= 1'b1;
    exp_inf <= 1'b0;
    exp_x   <= 0;
    exp_y   <= 0;
    none = '{inf: 1'b1, x: 0, y: 0};
    g    = none;
    t2   = none;
    best = 0;
    // All affine points of y^2 = x^3 + 7
    n_pts = 0;
    for (int x = 0; x < P_MOD; x++) begin
      for (int y = 0; y < P_MOD; y++) begin
        if (fmul(y, y) == fadd(fmul(fmul(x, x), x), B_COEF)) begin
          pts[n_pts] = '{inf: 1'b0, x: x, y: y};
          n_pts++;
        end
      end
    end
    for (int i = 0; i < n_pts; i++) begin
      if (pts[i].y == 0) t2 = pts[i];
    end
    for (int i = 0; i < n_pts && i < 32; i++) begin
      ord = point_order(pts[i]);
      if (ord > best) begin
        best = ord;
        g    = pts[i];
      end
    end

    for (int i = 0; i < 16; i++) begin
      a = pick_point();
      b = int'(next_rand() & 32'hff);
      add_entry(REQ_MULT, pts[a], none, b);
    end
    add_entry(REQ_MULT, g, none, 1);
    add_entry(REQ_MULT, g, none, 0);
    add_entry(REQ_MULT, g, none, best);
    add_entry(REQ_MULT, g, none, 255);
    add_entry(REQ_MULT, t2, none, 2);
    neg = '{inf: 1'b0, x: g.x, y: fsub(0, g.y)};
    add_entry(REQ_ADD, g, pt_dbl(g), 0);
    add_entry(REQ_ADD, g, g, 0);
    add_entry(REQ_ADD, g, neg, 0);
    add_entry(REQ_ADD, t2, t2, 0);
    for (int i = 0; i < 3; i++) begin
      a = pick_point();
      b = pick_point();
      add_entry(REQ_ADD, pts[a], pts[b], 0);
    end
    limit = n_ent * 1200 + 100;

    repeat (2) @(posedge i_clk);
    i_rst <= 1'b0;
    for (int n = 0; n < n_ent; n++) run_entry(n);
    repeat (4) @(posedge i_clk);

    $display("Results checked: %0d of %0d, errors: %0d", checks, n_ent, errors);
    if (errors == 0 && checks == n_ent) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- test/ec_scalar_checker.sv
// Checker that watches the DUT ports, compares results with the model and counts errors
module ec_scalar_checker (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_req_val,
  input  logic       i_req_rdy,
  input  logic       i_res_val,
  input  logic       i_res_rdy,
  input  logic [7:0] i_res_x,
  input  logic [7:0] i_res_y,
  input  logic [7:0] i_res_z,
  input  logic       i_res_err,
  input  logic       i_exp_inf,
  input  int         i_exp_x,
  input  int         i_exp_y,
  output int         o_errors,
  output int         o_checks
);

  int          errors = 0;
  int          checks = 0;
  int          rst_age = 0;
  logic        pending = 1'b0;
  logic        hold_prev = 1'b0;
  logic        want_inf;
  int          want_x, want_y;
  logic [25:0] held;

  assign o_errors = errors;
  assign o_checks = checks;

  function automatic int mul_mod(int a, int b);
    return (a * b) % 251;
  endfunction

  task automatic flag_value(input string name, input logic [7:0] got, input logic [7:0] want);
    errors++;
    $display("[FAIL] %s: got %h expected %h", name, got, want);
  endtask

  task automatic flag_event(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // Jacobian result matches affine (x, y) when X = x*Z^2 and Y = y*Z^3
  task automatic check_result();
    int z2;
    int ex;
    int ey;
    checks++;
    z2 = mul_mod(int'(i_res_z), int'(i_res_z));
    ex = mul_mod(want_x, z2);
    ey = mul_mod(mul_mod(want_y, z2), int'(i_res_z));
    if (want_inf) begin
      if (i_res_z != 8'd0) flag_value("o_z", i_res_z, 8'd0);
      if (!i_res_err) flag_value("o_err", 8'(i_res_err), 8'd1);
    end else if (i_res_z == 8'd0) begin
      flag_event("result is the point at infinity where a finite point was expected");
    end else begin
      if (i_res_err) flag_value("o_err", 8'(i_res_err), 8'd0);
      if (int'(i_res_x) != ex) flag_value("o_x", i_res_x, 8'(ex));
      if (int'(i_res_y) != ey) flag_value("o_y", i_res_y, 8'(ey));
    end
  endtask

  always @(negedge i_clk) begin
    if (i_rst) begin
      rst_age   = 0;
      pending   = 1'b0;
      hold_prev = 1'b0;
    end else begin
      if (rst_age < 3) rst_age++;
      if (rst_age == 1 && (i_req_rdy || i_res_val || i_res_err))
        flag_event("o_rdy, o_val or o_err high in the first cycle after reset");
      if (rst_age == 2 && !i_req_rdy)
        flag_event("o_rdy did not rise one cycle after reset");
      // Held result must not move while i_rdy is low
      if (hold_prev && held != {i_res_val, i_res_err, i_res_x, i_res_y, i_res_z})
        flag_event("result outputs changed while i_rdy was low");
      hold_prev = i_res_val && !i_res_rdy;
      held      = {i_res_val, i_res_err, i_res_x, i_res_y, i_res_z};
      if (pending && i_req_rdy)
        flag_event("o_rdy high while a request is still pending");
      if (i_res_val) begin
        if (!pending) begin
          flag_event("o_val high without a pending request");
        end else if (i_res_rdy) begin
          check_result();
          pending = 1'b0;
        end
      end
      if (i_req_val && i_req_rdy) begin
        if (pending) flag_event("request accepted before the previous result was taken");
        pending  = 1'b1;
        want_inf = i_exp_inf;
        want_x   = i_exp_x;
        want_y   = i_exp_y;
      end
    end
  end

endmodule

//--- logic/ec_scalar_top.sv
// Top level of the scalar point multiplier with plain ports
module ec_scalar_top (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  ec_point_pkg::req_kind_e i_kind,
  input  ec_field_pkg::fe_t       i_px,
  input  ec_field_pkg::fe_t       i_py,
  input  ec_field_pkg::fe_t       i_qx,
  input  ec_field_pkg::fe_t       i_qy,
  input  ec_field_pkg::scalar_t   i_k,
  input  logic                    i_val,
  output logic                    o_rdy,
  output ec_field_pkg::fe_t       o_x,
  output ec_field_pkg::fe_t       o_y,
  output ec_field_pkg::fe_t       o_z,
  output logic                    o_err,
  output logic                    o_val,
  input  logic                    i_rdy
);
  import ec_field_pkg::*;
  import ec_point_pkg::*;

  jpoint_t     p_in, q_in, res;
  jpoint_t     dbl_in, dbl_out, add_p1, add_p2, add_out;
  logic        dbl_in_val, dbl_in_rdy, dbl_out_val, dbl_out_rdy;
  logic        add_in_val, add_in_rdy, add_out_val, add_out_rdy;
  add_status_e add_status;

  mult_if dbl_mult ();
  mult_if add_mult ();
  mult_if core_mult ();

  // Affine inputs become Jacobian points with Z = 1
  assign p_in = '{x: i_px, y: i_py, z: fe_t'(1)};
  assign q_in = '{x: i_qx, y: i_qy, z: fe_t'(1)};
  assign o_x  = res.x;
  assign o_y  = res.y;
  assign o_z  = res.z;

  point_mult u_point_mult (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_kind       (i_kind),
    .i_p          (p_in),
    .i_q          (q_in),
    .i_k          (i_k),
    .i_val        (i_val),
    .o_rdy        (o_rdy),
    .o_p          (res),
    .o_err        (o_err),
    .o_val        (o_val),
    .i_rdy        (i_rdy),
    .o_dbl_p      (dbl_in),
    .o_dbl_val    (dbl_in_val),
    .i_dbl_rdy    (dbl_in_rdy),
    .i_dbl_p      (dbl_out),
    .i_dbl_val    (dbl_out_val),
    .o_dbl_rdy    (dbl_out_rdy),
    .o_add_p1     (add_p1),
    .o_add_p2     (add_p2),
    .o_add_val    (add_in_val),
    .i_add_rdy    (add_in_rdy),
    .i_add_p      (add_out),
    .i_add_status (add_status),
    .i_add_val    (add_out_val),
    .o_add_rdy    (add_out_rdy)
  );

  point_dbl u_point_dbl (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_p    (dbl_in),
    .i_val  (dbl_in_val),
    .o_rdy  (dbl_in_rdy),
    .o_p    (dbl_out),
    .o_val  (dbl_out_val),
    .i_rdy  (dbl_out_rdy),
    .o_mult (dbl_mult.client)
  );

  point_add u_point_add (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_p1     (add_p1),
    .i_p2     (add_p2),
    .i_val    (add_in_val),
    .o_rdy    (add_in_rdy),
    .o_p      (add_out),
    .o_status (add_status),
    .o_val    (add_out_val),
    .i_rdy    (add_out_rdy),
    .o_mult   (add_mult.client)
  );

  mult_arbiter u_mult_arbiter (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_dbl  (dbl_mult.server),
    .i_add  (add_mult.server),
    .o_mult (core_mult.client)
  );

  mod_mult u_mod_mult (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (core_mult.server)
  );

endmodule

//--- logic/point_mult.sv
// Double-and-add controller with request capture and held result output
module point_mult (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  ec_point_pkg::req_kind_e   i_kind,
  input  ec_point_pkg::jpoint_t     i_p,
  input  ec_point_pkg::jpoint_t     i_q,
  input  ec_field_pkg::scalar_t     i_k,
  input  logic                      i_val,
  output logic                      o_rdy,
  output ec_point_pkg::jpoint_t     o_p,
  output logic                      o_err,
  output logic                      o_val,
  input  logic                      i_rdy,
  output ec_point_pkg::jpoint_t     o_dbl_p,
  output logic                      o_dbl_val,
  input  logic                      i_dbl_rdy,
  input  ec_point_pkg::jpoint_t     i_dbl_p,
  input  logic                      i_dbl_val,
  output logic                      o_dbl_rdy,
  output ec_point_pkg::jpoint_t     o_add_p1,
  output ec_point_pkg::jpoint_t     o_add_p2,
  output logic                      o_add_val,
  input  logic                      i_add_rdy,
  input  ec_point_pkg::jpoint_t     i_add_p,
  input  ec_point_pkg::add_status_e i_add_status,
  input  logic                      i_add_val,
  output logic                      o_add_rdy
);
  import ec_field_pkg::*;
  import ec_point_pkg::*;

  typedef enum logic [1:0] {IDLE, DOUBLE_ADD, ADD_ONLY, FINISHED} state_e;

  state_e  state;
  jpoint_t p_q, p_n;
  scalar_t k_l;
  logic    dbl_busy, add_busy;
  // same_pend waits for the doubling fallback, fix_dbl sends the doubler result to Q
  logic    same_pend, fix_dbl, dbl_step;

  assign o_dbl_p   = p_n;
  assign o_add_p1  = p_q;
  assign o_add_p2  = p_n;
  assign o_dbl_rdy = dbl_busy;
  assign o_add_rdy = add_busy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= IDLE;
      o_rdy     <= 1'b0;
      o_val     <= 1'b0;
      o_err     <= 1'b0;
      o_dbl_val <= 1'b0;
      o_add_val <= 1'b0;
      dbl_busy  <= 1'b0;
      add_busy  <= 1'b0;
      same_pend <= 1'b0;
      fix_dbl   <= 1'b0;
      dbl_step  <= 1'b0;
    end else begin
      if (i_dbl_rdy) o_dbl_val <= 1'b0;
      if (i_add_rdy) o_add_val <= 1'b0;

      if (i_dbl_val && o_dbl_rdy) begin
        dbl_busy <= 1'b0;
        fix_dbl  <= 1'b0;
        if (fix_dbl) p_q <= i_dbl_p;
        else p_n <= i_dbl_p;
      end
      if (i_add_val && o_add_rdy) begin
        add_busy <= 1'b0;
        if (i_add_status == ADD_SAME) same_pend <= 1'b1;
        else p_q <= i_add_p;
      end

      case (state)
        IDLE: begin
          o_rdy <= 1'b1;
          if (o_rdy && i_val) begin
            o_rdy    <= 1'b0;
            p_n      <= i_p;
            dbl_step <= 1'b0;
            if (i_kind == REQ_ADD) begin
              p_q       <= i_q;
              o_add_val <= 1'b1;
              add_busy  <= 1'b1;
              state     <= ADD_ONLY;
            end else begin
              // Accumulator starts at infinity
              p_q   <= '0;
              k_l   <= i_k;
              state <= DOUBLE_ADD;
            end
          end
        end
        DOUBLE_ADD, ADD_ONLY: begin
          if (!dbl_busy && !add_busy) begin
            if (same_pend) begin
              // Q equalled N, so Q + N is 2N, already in N if this bit doubled
              same_pend <= 1'b0;
              if (dbl_step) begin
                p_q <= p_n;
              end else begin
                o_dbl_val <= 1'b1;
                dbl_busy  <= 1'b1;
                fix_dbl   <= 1'b1;
              end
            end else if (state == ADD_ONLY) begin
              o_p   <= p_q;
              o_err <= (p_q.z == '0);
              o_val <= 1'b1;
              state <= FINISHED;
            end else begin
              // Add and double for this bit run side by side
              k_l      <= k_l >> 1;
              dbl_step <= |k_l[K_BITS-1:1];
              if (k_l[0]) begin
                o_add_val <= 1'b1;
                add_busy  <= 1'b1;
              end
              if (|k_l[K_BITS-1:1]) begin
                o_dbl_val <= 1'b1;
                dbl_busy  <= 1'b1;
              end else begin
                state <= ADD_ONLY;
              end
            end
          end
        end
        FINISHED: begin
          if (i_rdy) begin
            o_val <= 1'b0;
            o_err <= 1'b0;
            state <= IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- logic/point_add.sv
// General Jacobian point addition with infinity and equal-point detection
module point_add (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  ec_point_pkg::jpoint_t     i_p1,
  input  ec_point_pkg::jpoint_t     i_p2,
  input  logic                      i_val,
  output logic                      o_rdy,
  output ec_point_pkg::jpoint_t     o_p,
  output ec_point_pkg::add_status_e o_status,
  output logic                      o_val,
  input  logic                      i_rdy,
  mult_if.client                    o_mult
);
  import ec_field_pkg::*;
  import ec_point_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_MUL, S_WAIT, S_DONE} state_e;

  state_e      state;
  jpoint_t     p1, p2, res;
  add_status_e status;
  fe_t         t [16];
  logic [3:0]  mi;
  logic [2:0]  pend;
  logic        issue, last;
  fe_t         h, r, x3, y3, op_a, op_b;

  // t5/t6 are U1/U2, t7/t8 are S1/S2, H = U2 - U1, R = S2 - S1
  always_comb begin
    h  = f_sub(t[6], t[5]);
    r  = f_sub(t[8], t[7]);
    x3 = f_sub(f_sub(t[10], t[12]), f_add(t[13], t[13]));
    y3 = f_sub(t[14], t[15]);
    case (mi)
      4'd0:  begin op_a = p1.z;  op_b = p1.z;  end
      4'd1:  begin op_a = p2.z;  op_b = p2.z;  end
      4'd2:  begin op_a = p1.z;  op_b = p2.z;  end
      4'd3:  begin op_a = p1.y;  op_b = p2.z;  end
      4'd4:  begin op_a = p2.y;  op_b = p1.z;  end
      4'd5:  begin op_a = p1.x;  op_b = t[1];  end
      4'd6:  begin op_a = p2.x;  op_b = t[0];  end
      4'd7:  begin op_a = t[3];  op_b = t[1];  end
      4'd8:  begin op_a = t[4];  op_b = t[0];  end
      4'd9:  begin op_a = h;     op_b = h;     end
      4'd10: begin op_a = r;     op_b = r;     end
      4'd11: begin op_a = h;     op_b = t[2];  end
      4'd12: begin op_a = h;     op_b = t[9];  end
      4'd13: begin op_a = t[5];  op_b = t[9];  end
      4'd14: begin op_a = r;     op_b = f_sub(t[13], x3); end
      default: begin op_a = t[7]; op_b = t[12]; end
    endcase
  end

  assign last  = mi inside {4'd4, 4'd8, 4'd11, 4'd13, 4'd15};
  assign issue = (state == S_MUL) && o_mult.req_rdy;

  assign o_mult.req_val = (state == S_MUL);
  assign o_mult.req_a   = op_a;
  assign o_mult.req_b   = op_b;
  assign o_mult.req_tag = {1'b0, mi};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= S_IDLE;
      mi    <= '0;
      pend  <= '0;
    end else begin
      pend <= pend + {2'b00, issue} - {2'b00, o_mult.resp_val};
      case (state)
        S_IDLE: if (i_val) begin
          mi    <= '0;
          state <= (i_p1.z == '0 || i_p2.z == '0) ? S_DONE : S_MUL;
        end
        S_MUL: if (issue) begin
          mi <= mi + 4'd1;
          if (last) state <= S_WAIT;
        end
        S_WAIT: if (pend == '0) begin
          // After U and S are known, equal x means same point or inverse
          if ((mi == 4'd9 && h == '0) || mi == 4'd0) state <= S_DONE;
          else state <= S_MUL;
        end
        S_DONE: if (i_rdy) state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      p1     <= i_p1;
      p2     <= i_p2;
      status <= ADD_OK;
      if (i_p1.z == '0) res <= i_p2;
      else res <= i_p1;
    end
    if (state == S_WAIT && pend == '0) begin
      if (mi == 4'd9 && h == '0) begin
        status <= (r == '0) ? ADD_SAME : ADD_INF;
        res    <= '0;
      end else if (mi == 4'd0) begin
        res <= '{x: x3, y: y3, z: t[11]};
      end
    end
    if (o_mult.resp_val) t[o_mult.resp_tag[3:0]] <= o_mult.resp_res;
  end

  assign o_p      = res;
  assign o_status = status;
  assign o_val    = (state == S_DONE);
  assign o_rdy    = (state == S_IDLE);

endmodule

//--- logic/point_dbl.sv
// Jacobian point doubling for a = 0 over the shared multiplier
module point_dbl (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  ec_point_pkg::jpoint_t i_p,
  input  logic                  i_val,
  output logic                  o_rdy,
  output ec_point_pkg::jpoint_t o_p,
  output logic                  o_val,
  input  logic                  i_rdy,
  mult_if.client                o_mult
);
  import ec_field_pkg::*;
  import ec_point_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_MUL, S_WAIT, S_DONE} state_e;

  state_e     state;
  jpoint_t    p;
  fe_t        t [8];
  logic [2:0] mi;
  logic [2:0] pend;
  logic       issue, last;
  fe_t        xb, e, d, x3, y3, z3, c8, op_a, op_b;

  // A = X^2, B = Y^2, C = B^2, D = 2((X+B)^2 - A - C), E = 3A, F = E^2
  always_comb begin
    xb = f_add(p.x, t[1]);
    e  = f_add(f_add(t[0], t[0]), t[0]);
    d  = f_sub(f_sub(t[4], t[0]), t[3]);
    d  = f_add(d, d);
    x3 = f_sub(t[5], f_add(d, d));
    c8 = f_add(t[3], t[3]);
    c8 = f_add(c8, c8);
    c8 = f_add(c8, c8);
    y3 = f_sub(t[6], c8);
    z3 = f_add(t[2], t[2]);
    case (mi)
      3'd0: begin op_a = p.x;  op_b = p.x;          end
      3'd1: begin op_a = p.y;  op_b = p.y;          end
      3'd2: begin op_a = p.y;  op_b = p.z;          end
      3'd3: begin op_a = t[1]; op_b = t[1];         end
      3'd4: begin op_a = xb;   op_b = xb;           end
      3'd5: begin op_a = e;    op_b = e;            end
      3'd6: begin op_a = e;    op_b = f_sub(d, x3); end
      default: begin op_a = '0; op_b = '0; end
    endcase
  end

  // Multiplies 0-2, 3-5 and 6 form the dependent groups
  assign last  = (mi == 3'd2) || (mi == 3'd5) || (mi == 3'd6);
  assign issue = (state == S_MUL) && o_mult.req_rdy;

  assign o_mult.req_val = (state == S_MUL);
  assign o_mult.req_a   = op_a;
  assign o_mult.req_b   = op_b;
  assign o_mult.req_tag = {2'b00, mi};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= S_IDLE;
      mi    <= '0;
      pend  <= '0;
    end else begin
      pend <= pend + {2'b00, issue} - {2'b00, o_mult.resp_val};
      case (state)
        S_IDLE: if (i_val) begin
          mi    <= '0;
          state <= S_MUL;
        end
        S_MUL: if (issue) begin
          mi <= mi + 3'd1;
          if (last) state <= S_WAIT;
        end
        S_WAIT: if (pend == '0) state <= (mi == 3'd7) ? S_DONE : S_MUL;
        S_DONE: if (i_rdy) state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) p <= i_p;
    if (o_mult.resp_val) t[o_mult.resp_tag[2:0]] <= o_mult.resp_res;
  end

  // Z3 = 2YZ, so infinity or y = 0 gives Z3 = 0 by itself
  assign o_p   = '{x: x3, y: y3, z: z3};
  assign o_val = (state == S_DONE);
  assign o_rdy = (state == S_IDLE);

endmodule

//--- logic/mult_arbiter.sv
// Round-robin sharing of the multiplier between doubler and adder, response routing by tag
module mult_arbiter (
  input logic    i_clk,
  input logic    i_rst,
  mult_if.server i_dbl,
  mult_if.server i_add,
  mult_if.client o_mult
);

  logic prio_add;
  logic gnt_dbl;
  logic gnt_add;

  always_comb begin
    gnt_dbl = i_dbl.req_val && (!i_add.req_val || !prio_add);
    gnt_add = i_add.req_val && !gnt_dbl;

    o_mult.req_val = gnt_dbl || gnt_add;
    o_mult.req_a   = gnt_add ? i_add.req_a : i_dbl.req_a;
    o_mult.req_b   = gnt_add ? i_add.req_b : i_dbl.req_b;
    // Tag bit 4 names the client for the way back
    o_mult.req_tag = gnt_add ? {1'b1, i_add.req_tag[3:0]} : {1'b0, i_dbl.req_tag[3:0]};

    i_dbl.req_rdy = gnt_dbl && o_mult.req_rdy;
    i_add.req_rdy = gnt_add && o_mult.req_rdy;

    i_dbl.resp_val = o_mult.resp_val && !o_mult.resp_tag[4];
    i_add.resp_val = o_mult.resp_val && o_mult.resp_tag[4];
    i_dbl.resp_res = o_mult.resp_res;
    i_add.resp_res = o_mult.resp_res;
    i_dbl.resp_tag = o_mult.resp_tag;
    i_add.resp_tag = o_mult.resp_tag;
  end

  // Client served last drops to low priority
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      prio_add <= 1'b0;
    end else if (o_mult.req_val && o_mult.req_rdy) begin
      prio_add <= gnt_dbl;
    end
  end

endmodule

//--- logic/mod_mult.sv
// Three-stage pipelined multiplier modulo p
module mod_mult (
  input logic    i_clk,
  input logic    i_rst,
  mult_if.server i_req
);
  import ec_field_pkg::*;

  logic [MULT_LAT-1:0] vld;
  logic                rdy;
  fe_t                 a1, b1, res3;
  mult_tag_t           tag1, tag2, tag3;
  logic [15:0]         prod2;
  logic [15:0]         red;

  // Product stays below 251 << 8, so subtracting p << 7 down to p << 0 is enough
  always_comb begin
    red = prod2;
    for (int s = 7; s >= 0; s--) begin
      if (red >= ({8'd0, FIELD_P} << s)) red = red - ({8'd0, FIELD_P} << s);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      vld <= '0;
      rdy <= 1'b0;
    end else begin
      vld <= {vld[MULT_LAT-2:0], i_req.req_val && rdy};
      rdy <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    a1    <= i_req.req_a;
    b1    <= i_req.req_b;
    tag1  <= i_req.req_tag;
    prod2 <= a1 * b1;
    tag2  <= tag1;
    res3  <= red[FE_BITS-1:0];
    tag3  <= tag2;
  end

  assign i_req.req_rdy  = rdy;
  assign i_req.resp_val = vld[MULT_LAT-1];
  assign i_req.resp_res = res3;
  assign i_req.resp_tag = tag3;

endmodule

//--- logic/mult_if.sv
// Request and response channel of the shared field multiplier
interface mult_if;
  import ec_field_pkg::*;

  logic      req_val;
  logic      req_rdy;
  fe_t       req_a;
  fe_t       req_b;
  mult_tag_t req_tag;

  // Response is a single-cycle pulse with no ready
  logic      resp_val;
  fe_t       resp_res;
  mult_tag_t resp_tag;

  modport client (
    output req_val, req_a, req_b, req_tag,
    input  req_rdy, resp_val, resp_res, resp_tag
  );

  modport server (
    input  req_val, req_a, req_b, req_tag,
    output req_rdy, resp_val, resp_res, resp_tag
  );

endinterface

//--- logic/ec_point_pkg.sv
// Jacobian point type, request kind and point adder status
package ec_point_pkg;

  // Z = 0 stands for the point at infinity
  typedef struct packed {
    ec_field_pkg::fe_t x;
    ec_field_pkg::fe_t y;
    ec_field_pkg::fe_t z;
  } jpoint_t;

  typedef enum logic {
    REQ_MULT,
    REQ_ADD
  } req_kind_e;

  // ADD_SAME means both inputs are one point, so the sum needs a doubling
  typedef enum logic [1:0] {
    ADD_OK,
    ADD_SAME,
    ADD_INF
  } add_status_e;

endpackage

//--- logic/ec_field_pkg.sv
// Field element and scalar types, modulus, curve constant, multiplier tags, mod-p add/sub
package ec_field_pkg;

  localparam int FE_BITS = 8;
  typedef logic [FE_BITS-1:0] fe_t;

  localparam fe_t FIELD_P = 8'd251;
  // Curve is y^2 = x^3 + 7, a = 0
  localparam fe_t CURVE_B = 8'd7;

  localparam int K_BITS = 8;
  typedef logic [K_BITS-1:0] scalar_t;

  localparam int MULT_LAT = 3;
  // Bit 4 is the client id, bits 3:0 the client's temp register index
  typedef logic [4:0] mult_tag_t;

  function automatic fe_t f_add(fe_t a, fe_t b);
    logic [FE_BITS:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, FIELD_P}) s = s - {1'b0, FIELD_P};
    return s[FE_BITS-1:0];
  endfunction

  function automatic fe_t f_sub(fe_t a, fe_t b);
    return (a >= b) ? a - b : a + (FIELD_P - b);
  endfunction

endpackage
